// ==== design/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    // one joint TLB entry holds an even/odd page pair sharing vpn2
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;     // global entry ignores asid
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        exc_none     = 2'd0,
        exc_refill   = 2'd1,
        exc_invalid  = 2'd2,
        exc_modified = 2'd3
    } tlb_exc_t;

    // segment boundaries
    parameter logic [31:0] KSEG0_BASE = 32'h8000_0000;
    parameter logic [31:0] KSEG1_BASE = 32'hA000_0000;
    parameter logic [31:0] KSEG2_BASE = 32'hC000_0000;

    parameter logic [2:0] CACHE_ATTR_CACHED = 3'd3;  // cacheable, noncoherent

    // index width for a given entry count with a minimum of one bit
    function automatic int TLB_INDEX_W(input int entries);
        int w;
        w = $clog2(entries);
        if (w < 1) begin
            w = 1;
        end
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== design/tlb_search_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one search port between a micro-TLB and the joint TLB
interface tlb_search_if;
    import mmu_pkg::*;

    logic [18:0] vpn2;   // page pair being looked up
    logic [7:0]  asid;   // current address space id
    logic        found;
    tlb_entry_t  entry;  // lowest matching entry

    modport requester (
        output vpn2,
        input  asid,
        input  found,
        input  entry
    );

    modport responder (
        input  vpn2,
        output asid,
        output found,
        output entry
    );

endinterface

`default_nettype wire

// ==== design/joint_tlb.sv ====
`timescale 1ns/100ps
`default_nettype none

module joint_tlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [7:0]                                    asid,
    input  logic                                          we,
    input  logic [mmu_pkg::TLB_INDEX_W(TLB_ENTRIES)-1:0]  index,
    input  mmu_pkg::tlb_entry_t                           wdata,
    tlb_search_if.responder                               inst_port,
    tlb_search_if.responder                               data_port
);
    import mmu_pkg::*;

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] inst_hits;
    logic [TLB_ENTRIES-1:0] data_hits;

    // entry array is cleared so no page is valid after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[index] <= wdata;
        end
    end

    // one hit bit per entry
    function automatic logic [TLB_ENTRIES-1:0] match_vec(
        input logic [18:0] req_vpn2,
        input logic [7:0]  req_asid
    );
        logic [TLB_ENTRIES-1:0] hits;
        hits = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hits[i] = (entries[i].vpn2 == req_vpn2) &&
                      (entries[i].g || entries[i].asid == req_asid);
        end
        return hits;
    endfunction

    // walk down so the lowest matching index is the one left
    function automatic tlb_entry_t pick(input logic [TLB_ENTRIES-1:0] hits);
        tlb_entry_t sel;
        sel = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                sel = entries[i];
            end
        end
        return sel;
    endfunction

    assign inst_port.asid = asid;
    assign data_port.asid = asid;

    // fetch side search
    always_comb begin
        inst_hits       = match_vec(inst_port.vpn2, inst_port.asid);
        inst_port.found = |inst_hits;
        inst_port.entry = pick(inst_hits);
    end

    // memory side search, independent of the fetch side
    always_comb begin
        data_hits       = match_vec(data_port.vpn2, data_port.asid);
        data_port.found = |data_hits;
        data_port.entry = pick(data_hits);
    end

endmodule

`default_nettype wire

// ==== design/inst_tlb_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_tlb_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       vaddr,
    input  logic              flush,
    tlb_search_if.requester   tlb,
    output logic [31:0]       paddr,
    output logic              cached,
    output logic              valid,
    output logic              stall,
    output mmu_pkg::tlb_exc_t exc
);
    import mmu_pkg::*;

    typedef enum logic {
        st_idle,
        st_search
    } state_t;

    state_t      state;
    state_t      state_next;
    tlb_entry_t  buf_entry;    // the one cached page pair
    logic        buf_in_tlb;   // joint TLB had a match at refill time
    logic        unmapped;
    logic        in_kseg1;
    logic        buf_hit;
    logic [19:0] sel_pfn;
    logic [2:0]  sel_c;
    logic        sel_v;

    // kseg0 and kseg1 bypass the TLB
    assign unmapped = (vaddr >= KSEG0_BASE) && (vaddr < KSEG2_BASE);
    assign in_kseg1 = vaddr >= KSEG1_BASE;
    assign buf_hit  = vaddr[31:13] == buf_entry.vpn2;
    assign stall    = !unmapped && !buf_hit;

    assign tlb.vpn2 = vaddr[31:13];

    // go to search on a miss and back to idle after one search cycle
    assign state_next = (state == st_idle && stall) ? st_search : st_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // refill from the joint TLB at the end of the search cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            buf_entry  <= '0;
            buf_in_tlb <= 1'b0;
        end else if (state == st_search) begin
            buf_entry      <= tlb.entry;
            buf_entry.vpn2 <= vaddr[31:13];  // tag from the request since the entry may be empty
            buf_in_tlb     <= tlb.found;
        end
    end

    // even or odd page by bit 12
    assign sel_pfn = vaddr[12] ? buf_entry.pfn1 : buf_entry.pfn0;
    assign sel_c   = vaddr[12] ? buf_entry.c1 : buf_entry.c0;
    assign sel_v   = vaddr[12] ? buf_entry.v1 : buf_entry.v0;

    always_comb begin
        if (unmapped) begin
            paddr  = in_kseg1 ? vaddr - KSEG1_BASE : vaddr - KSEG0_BASE;
            cached = !in_kseg1;
        end else begin
            paddr  = {sel_pfn, vaddr[11:0]};
            cached = sel_c == CACHE_ATTR_CACHED;
        end
    end

    // fetch exceptions
    always_comb begin
        if (unmapped) begin
            valid = 1'b1;
            exc   = exc_none;
        end else if (!buf_hit) begin
            valid = 1'b0;   // still searching so the type is not known yet
            exc   = exc_none;
        end else if (!buf_in_tlb) begin
            valid = 1'b0;
            exc   = exc_refill;
        end else if (!sel_v) begin
            valid = 1'b0;
            exc   = exc_invalid;
        end else begin
            valid = 1'b1;
            exc   = exc_none;
        end
    end

endmodule

`default_nettype wire

// ==== design/data_tlb_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_tlb_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       vaddr,
    input  logic              store,
    input  logic              flush,
    tlb_search_if.requester   tlb,
    output logic [31:0]       paddr,
    output logic              cached,
    output logic              valid,
    output logic              stall,
    output mmu_pkg::tlb_exc_t exc
);
    import mmu_pkg::*;

    typedef enum logic {
        st_idle,
        st_search
    } state_t;

    state_t      state;
    state_t      state_next;
    tlb_entry_t  buf_entry;
    logic        buf_in_tlb;
    logic        unmapped;
    logic        in_kseg1;
    logic        buf_hit;
    logic [19:0] sel_pfn;
    logic [2:0]  sel_c;
    logic        sel_v;
    logic        sel_d;   // page writable

    assign unmapped = (vaddr >= KSEG0_BASE) && (vaddr < KSEG2_BASE);
    assign in_kseg1 = vaddr >= KSEG1_BASE;
    assign buf_hit  = vaddr[31:13] == buf_entry.vpn2;
    assign stall    = !unmapped && !buf_hit;  // miss holds the memory stage

    assign tlb.vpn2 = vaddr[31:13];

    assign state_next = (state == st_idle && stall) ? st_search : st_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // flush wins over a refill in the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            buf_entry  <= '0;
            buf_in_tlb <= 1'b0;
        end else if (state == st_search) begin
            buf_entry      <= tlb.entry;
            buf_entry.vpn2 <= vaddr[31:13];
            buf_in_tlb     <= tlb.found;
        end
    end

    assign sel_pfn = vaddr[12] ? buf_entry.pfn1 : buf_entry.pfn0;
    assign sel_c   = vaddr[12] ? buf_entry.c1 : buf_entry.c0;
    assign sel_v   = vaddr[12] ? buf_entry.v1 : buf_entry.v0;
    assign sel_d   = vaddr[12] ? buf_entry.d1 : buf_entry.d0;

    // kseg1 uncached, kseg0 cached, mapped pages by C field
    always_comb begin
        if (unmapped) begin
            paddr  = in_kseg1 ? vaddr - KSEG1_BASE : vaddr - KSEG0_BASE;
            cached = !in_kseg1;
        end else begin
            paddr  = {sel_pfn, vaddr[11:0]};
            cached = sel_c == CACHE_ATTR_CACHED;
        end
    end

    always_comb begin
        if (unmapped) begin
            valid = 1'b1;
            exc   = exc_none;
        end else if (!buf_hit) begin
            valid = 1'b0;
            exc   = exc_none;
        end else if (!buf_in_tlb) begin
            valid = 1'b0;   // no joint TLB entry for this pair
            exc   = exc_refill;
        end else if (!sel_v) begin
            valid = 1'b0;
            exc   = exc_invalid;
        end else if (store && !sel_d) begin
            valid = 1'b0;   // write to a clean page
            exc   = exc_modified;
        end else begin
            valid = 1'b1;
            exc   = exc_none;
        end
    end

endmodule

`default_nettype wire

// ==== design/mmu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmu_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [31:0]                                   if_vaddr,
    input  logic [31:0]                                   mem_vaddr,
    input  logic                                          mem_store,
    input  logic [7:0]                                    asid,
    input  logic                                          tlb_flush,
    input  logic                                          tlb_we,
    input  logic [mmu_pkg::TLB_INDEX_W(TLB_ENTRIES)-1:0]  tlb_index,
    input  mmu_pkg::tlb_entry_t                           tlb_wdata,
    output logic [31:0]                                   if_paddr,
    output logic                                          if_cached,
    output logic                                          if_valid,
    output logic                                          if_stall,
    output mmu_pkg::tlb_exc_t                             if_exc,
    output logic [31:0]                                   mem_paddr,
    output logic                                          mem_cached,
    output logic                                          mem_valid,
    output logic                                          mem_stall,
    output mmu_pkg::tlb_exc_t                             mem_exc
);

    // one search port per pipeline side
    tlb_search_if inst_search ();
    tlb_search_if data_search ();

    joint_tlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_jtlb (
        .clk       (clk),
        .rst       (rst),
        .asid      (asid),
        .we        (tlb_we),
        .index     (tlb_index),
        .wdata     (tlb_wdata),
        .inst_port (inst_search.responder),
        .data_port (data_search.responder)
    );

    inst_tlb_buffer u_itlb (
        .clk    (clk),
        .rst    (rst),
        .vaddr  (if_vaddr),
        .flush  (tlb_flush),
        .tlb    (inst_search.requester),
        .paddr  (if_paddr),
        .cached (if_cached),
        .valid  (if_valid),
        .stall  (if_stall),
        .exc    (if_exc)
    );

    data_tlb_buffer u_dtlb (
        .clk    (clk),
        .rst    (rst),
        .vaddr  (mem_vaddr),
        .store  (mem_store),
        .flush  (tlb_flush),
        .tlb    (data_search.requester),
        .paddr  (mem_paddr),
        .cached (mem_cached),
        .valid  (mem_valid),
        .stall  (mem_stall),
        .exc    (mem_exc)
    );

endmodule

`default_nettype wire

// ==== tb/mmu_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmu_sva (
    input logic              clk,
    input logic              rst,
    input logic [31:0]       if_vaddr,
    input logic [31:0]       mem_vaddr,
    input logic              if_stall,
    input logic              if_valid,
    input mmu_pkg::tlb_exc_t if_exc,
    input logic              mem_stall,
    input logic              mem_valid,
    input mmu_pkg::tlb_exc_t mem_exc
);
    import mmu_pkg::*;

    int fail_count = 0;  // number of failed assertions

    function automatic logic is_unmapped(input logic [31:0] va);
        return (va >= KSEG0_BASE) && (va < KSEG2_BASE);
    endfunction

    // a held miss clears after the search cycle
    if_stall_len: assert property (@(posedge clk) disable iff (rst)
        if_stall ##1 (if_stall && $stable(if_vaddr)) |=> !if_stall || !$stable(if_vaddr))
    else begin
        $error("fetch stall held longer than 2 cycles");
        fail_count++;
    end

    mem_stall_len: assert property (@(posedge clk) disable iff (rst)
        mem_stall ##1 (mem_stall && $stable(mem_vaddr)) |=> !mem_stall || !$stable(mem_vaddr))
    else begin
        $error("memory stall held longer than 2 cycles");
        fail_count++;
    end

    // first cycle out of reset
    reset_no_stall: assert property (@(posedge clk)
        $fell(rst) |-> (!is_unmapped(if_vaddr) || !if_stall) &&
                       (!is_unmapped(mem_vaddr) || !mem_stall))
    else begin
        $error("stall high right after reset on an unmapped address");
        fail_count++;
    end

    if_unmapped: assert property (@(posedge clk) disable iff (rst)
        is_unmapped(if_vaddr) |-> !if_stall && if_valid && if_exc == exc_none)
    else begin
        $error("unmapped fetch stalled or raised an exception");
        fail_count++;
    end

    mem_unmapped: assert property (@(posedge clk) disable iff (rst)
        is_unmapped(mem_vaddr) |-> !mem_stall && mem_valid && mem_exc == exc_none)
    else begin
        $error("unmapped data access stalled or raised an exception");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/tb_mmu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mmu;
    import mmu_pkg::*;

    localparam int ENTRIES = 16;
    localparam int IDX_W   = TLB_INDEX_W(ENTRIES);

    logic             clk = 1'b0;
    logic             rst;
    logic [31:0]      if_vaddr;
    logic [31:0]      mem_vaddr;
    logic             mem_store;
    logic [7:0]       asid;
    logic             tlb_flush;
    logic             tlb_we;
    logic [IDX_W-1:0] tlb_index;
    tlb_entry_t       tlb_wdata;
    logic [31:0]      if_paddr;
    logic             if_cached;
    logic             if_valid;
    logic             if_stall;
    tlb_exc_t         if_exc;
    logic [31:0]      mem_paddr;
    logic             mem_cached;
    logic             mem_valid;
    logic             mem_stall;
    tlb_exc_t         mem_exc;

    tlb_entry_t  model_tlb [ENTRIES];  // every entry written so far
    tlb_entry_t  model_buf [2];        // 0 fetch side, 1 data side
    logic [18:0] model_tag [2];
    logic        model_found [2];
    logic [15:0] lfsr;
    int          checks;
    int          errors;

    mmu_top #(.TLB_ENTRIES(ENTRIES)) DUT (.*);

    bind mmu_top mmu_sva u_sva (.*);

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // vpn2 in kuseg with the index in the low bits to keep pairs distinct
    function automatic tlb_entry_t random_entry(input int idx);
        tlb_entry_t e;
        e.vpn2 = {1'b0, 13'(lfsr_bits(13)), 1'b1, 4'(idx)};
        e.asid = 8'h05;
        e.g    = 1'(lfsr_bits(1));
        e.pfn0 = 20'(lfsr_bits(20));
        e.c0   = lfsr_bits(1) != 0 ? CACHE_ATTR_CACHED : 3'd2;
        e.d0   = 1'(lfsr_bits(1));
        e.v0   = 1'b1;
        e.pfn1 = 20'(lfsr_bits(20));
        e.c1   = lfsr_bits(1) != 0 ? CACHE_ATTR_CACHED : 3'd2;
        e.d1   = 1'(lfsr_bits(1));
        e.v1   = 1'b1;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic write_entry(input int idx, input tlb_entry_t e);
        @(posedge clk);
        #2;
        tlb_we    = 1'b1;
        tlb_index = IDX_W'(idx);
        tlb_wdata = e;
        @(posedge clk);
        #2;
        tlb_we = 1'b0;
        model_tlb[idx] = e;
    endtask

    // park both ports on unmapped addresses while the buffers clear
    task automatic flush_buffers();
        @(posedge clk);
        #2;
        if_vaddr  = 32'h8000_1000;
        mem_vaddr = 32'hA000_2000;
        tlb_flush = 1'b1;
        @(posedge clk);
        #2;
        tlb_flush = 1'b0;
        for (int s = 0; s < 2; s++) begin
            model_tag[s]   = '0;
            model_found[s] = 1'b0;
            model_buf[s]   = '0;
        end
    endtask

    // expected result that also updates the modelled buffer on a miss
    task automatic predict(input bit side, input logic [31:0] va, input logic st,
                           output int stalls, output logic [31:0] pa, output logic ca,
                           output logic vl, output tlb_exc_t ex);
        tlb_entry_t  e;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        v;
        logic        d;
        stalls = 0;
        pa     = '0;
        ca     = 1'b0;
        vl     = 1'b0;
        ex     = exc_none;
        if (va >= KSEG0_BASE && va < KSEG2_BASE) begin
            pa = va - ((va >= KSEG1_BASE) ? KSEG1_BASE : KSEG0_BASE);
            ca = va < KSEG1_BASE;
            vl = 1'b1;
        end else begin
            if (va[31:13] != model_tag[side]) begin
                stalls            = 2;  // miss cycle plus search cycle
                model_tag[side]   = va[31:13];
                model_found[side] = 1'b0;
                model_buf[side]   = '0;
                for (int i = 0; i < ENTRIES; i++) begin
                    if (!model_found[side] && model_tlb[i].vpn2 == va[31:13] &&
                        (model_tlb[i].g || model_tlb[i].asid == asid)) begin
                        model_found[side] = 1'b1;
                        model_buf[side]   = model_tlb[i];
                    end
                end
            end
            e   = model_buf[side];
            pfn = va[12] ? e.pfn1 : e.pfn0;
            c   = va[12] ? e.c1 : e.c0;
            v   = va[12] ? e.v1 : e.v0;
            d   = va[12] ? e.d1 : e.d0;
            if (!model_found[side]) begin
                ex = exc_refill;
            end else if (!v) begin
                ex = exc_invalid;
            end else if (side && st && !d) begin
                ex = exc_modified;
            end else begin
                vl = 1'b1;
                pa = {pfn, va[11:0]};
                ca = c == CACHE_ATTR_CACHED;
            end
        end
    endtask

    task automatic access(input string name, input bit side, input logic [31:0] va,
                          input logic st);
        int          exp_stalls;
        int          stalls;
        logic [31:0] exp_pa;
        logic        exp_ca;
        logic        exp_vl;
        tlb_exc_t    exp_ex;
        predict(side, va, st, exp_stalls, exp_pa, exp_ca, exp_vl, exp_ex);
        @(posedge clk);
        #2;
        if (side) begin
            mem_vaddr = va;
            mem_store = st;
        end else begin
            if_vaddr = va;
        end
        stalls = 0;
        @(negedge clk);
        while ((side ? mem_stall : if_stall) && stalls < 10) begin
            stalls++;
            @(negedge clk);
        end
        assert (!(side ? mem_stall : if_stall)) else begin
            errors++;
            $display("%s: stall still high after 10 cycles", name);
        end
        check_val({name, " stalls"}, 32'(exp_stalls), 32'(stalls));
        check_val({name, " valid"}, 32'(exp_vl), 32'(side ? mem_valid : if_valid));
        check_val({name, " exc"}, 32'(exp_ex), 32'(side ? mem_exc : if_exc));
        if (exp_vl) begin
            check_val({name, " paddr"}, exp_pa, side ? mem_paddr : if_paddr);
            check_val({name, " cached"}, 32'(exp_ca), 32'(side ? mem_cached : if_cached));
        end
    endtask

    initial begin
        logic [31:0] off;
        logic [31:0] va;
        tlb_entry_t  e;
        rst       = 1'b1;
        if_vaddr  = 32'h8000_0000;
        mem_vaddr = 32'hA000_0000;
        mem_store = 1'b0;
        asid      = 8'h05;
        tlb_flush = 1'b0;
        tlb_we    = 1'b0;
        tlb_index = '0;
        tlb_wdata = '0;
        lfsr      = 16'd86;
        checks    = 0;
        errors    = 0;
        for (int i = 0; i < ENTRIES; i++) begin
            model_tlb[i] = '0;
        end
        for (int s = 0; s < 2; s++) begin
            model_tag[s]   = '0;
            model_found[s] = 1'b0;
            model_buf[s]   = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // pair 0 hits the empty buffer out of reset
        access("reset_pair0_if", 0, 32'h0000_0040, 1'b0);
        access("reset_pair0_mem", 1, 32'h0000_1080, 1'b1);

        repeat (8) begin
            off = lfsr_bits(29);
            access("kseg0_if", 0, KSEG0_BASE + off, 1'b0);
            access("kseg1_mem", 1, KSEG1_BASE + off, 1'(lfsr_bits(1)));
            off = lfsr_bits(29);
            access("kseg1_if", 0, KSEG1_BASE + off, 1'b0);
            access("kseg0_mem", 1, KSEG0_BASE + off, 1'(lfsr_bits(1)));
        end

        for (int k = 0; k < ENTRIES; k++) begin
            write_entry(k, random_entry(k));
        end
        for (int k = 0; k < 8; k++) begin
            va = {model_tlb[k].vpn2, 1'b0, 12'(lfsr_bits(12))};
            access("map_even_if", 0, va, 1'b0);
            access("map_even_if_hit", 0, va, 1'b0);
            access("map_odd_mem", 1, va | 32'h1000, 1'b0);
            access("map_odd_mem_hit", 1, va | 32'h1000, 1'b0);
        end

        access("refill_if", 0, 32'hE123_4560, 1'b0);
        access("refill_mem", 1, 32'hC0FF_E010, 1'b1);
        e      = random_entry(3);
        e.g    = 1'b0;
        e.asid = 8'h77;   // other address space
        write_entry(3, e);
        access("asid_if", 0, {e.vpn2, 13'h0123}, 1'b0);
        access("asid_mem", 1, {e.vpn2, 13'h1456}, 1'b0);

        e    = random_entry(4);
        e.v0 = 1'b0;
        write_entry(4, e);
        access("invalid_if", 0, {e.vpn2, 13'h0200}, 1'b0);
        access("invalid_mem", 1, {e.vpn2, 13'h0abc}, 1'b0);

        e    = random_entry(5);
        e.d0 = 1'b0;      // clean page
        write_entry(5, e);
        va = {e.vpn2, 13'h0344};
        access("store_miss", 1, va, 1'b1);
        access("load_hit", 1, va, 1'b0);
        access("store_hit", 1, va, 1'b1);
        flush_buffers();
        access("load_miss", 1, va, 1'b0);
        access("store_hit2", 1, va, 1'b1);

        e.pfn0 = e.pfn0 ^ 20'hf0f0f;
        write_entry(5, e);
        flush_buffers();
        access("new_pfn_mem", 1, va, 1'b0);
        access("new_pfn_if", 0, va, 1'b0);

        errors = errors + DUT.u_sva.fail_count;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/mmu_pkg.sv
design/tlb_search_if.sv
design/joint_tlb.sv
design/inst_tlb_buffer.sv
design/data_tlb_buffer.sv
design/mmu_top.sv
tb/mmu_sva.sv
tb/tb_mmu.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - design/mmu_pkg.sv
  - design/tlb_search_if.sv
  - design/joint_tlb.sv
  - design/inst_tlb_buffer.sv
  - design/data_tlb_buffer.sv
  - design/mmu_top.sv
  - target: simulation
    files:
      - tb/mmu_sva.sv
      - tb/tb_mmu.sv
